//--- design/rp_macros.svh
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// Sample and bus widths
`define RP_ADC_W        16
`define RP_DAC_W        14
`define RP_BUS_AW       32
`define RP_BUS_DW       32

// Address map, region field sits above the peer offset
`define RP_REGION_LSB   20
`define RP_REGION_W     3
`define RP_OFFSET_W     8
`define RP_REGION_HK    3'd0
`define RP_REGION_GEN   3'd1
`define RP_REGION_PC    3'd2

// Controller gain
`define RP_KP_W         8
`define RP_KP_SHIFT     4

// Housekeeping
`define RP_LED_W        8
`define RP_ID_VALUE     32'h52500001
`define RP_HK_ID_OFS    8'h00
`define RP_HK_LED_OFS   8'h04
`define RP_HK_LOOP_OFS  8'h08

// DC level generator
`define RP_GEN_LVL_A_OFS 8'h00
`define RP_GEN_LVL_B_OFS 8'h04

// Proportional controller
`define RP_PC_SP_A_OFS  8'h00
`define RP_PC_SP_B_OFS  8'h04
`define RP_PC_KP_A_OFS  8'h08
`define RP_PC_KP_B_OFS  8'h0C

`endif

//--- design/rp_pkg.sv
`include "rp_macros.svh"

package rp_pkg;

  // Sample types, two's complement
  typedef logic signed [`RP_ADC_W-1:0] adc_sample_t;
  typedef logic signed [`RP_DAC_W-1:0] dac_sample_t;

  // System bus
  typedef logic [`RP_BUS_AW-1:0]       bus_addr_t;
  typedef logic [`RP_BUS_DW-1:0]       bus_data_t;
  typedef logic [`RP_OFFSET_W-1:0]     reg_offset_t;  // Offset inside one region

  // Controller gain, signed
  typedef logic signed [`RP_KP_W-1:0]  kp_t;

  typedef logic [`RP_LED_W-1:0]        led_t;

endpackage

//--- design/sys_bus_decoder.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module sys_bus_decoder (
  input  logic                adc_clk,
  input  logic                reset_i,
  // Master side
  input  rp_pkg::bus_addr_t   sys_addr_i,
  input  rp_pkg::bus_data_t   sys_wdata_i,
  input  logic                sys_wen_i,
  input  logic                sys_ren_i,
  output rp_pkg::bus_data_t   sys_rdata_o,
  output logic                sys_ack_o,
  output logic                sys_err_o,
  // Shared towards all peers
  output rp_pkg::reg_offset_t reg_offset_o,
  output rp_pkg::bus_data_t   reg_wdata_o,
  // Housekeeping, region 0
  output logic                hk_wen_o,
  output logic                hk_ren_o,
  input  rp_pkg::bus_data_t   hk_rdata_i,
  input  logic                hk_ack_i,
  // DC level generator, region 1
  output logic                gen_wen_o,
  output logic                gen_ren_o,
  input  rp_pkg::bus_data_t   gen_rdata_i,
  input  logic                gen_ack_i,
  // Proportional controller, region 2
  output logic                pc_wen_o,
  output logic                pc_ren_o,
  input  rp_pkg::bus_data_t   pc_rdata_i,
  input  logic                pc_ack_i
);

  logic [`RP_REGION_W-1:0] region;   // Region of the current strobe
  logic [`RP_REGION_W-1:0] pend_q;   // Region of the access in flight
  logic                    hit_hk;
  logic                    hit_gen;
  logic                    hit_pc;
  logic                    unmapped;
  logic                    strobe;
  logic                    err_q;    // Local error answer

  //////////////////////////////
  // Address split

  assign region       = sys_addr_i[`RP_REGION_LSB +: `RP_REGION_W];
  assign reg_offset_o = sys_addr_i[`RP_OFFSET_W-1:0];  // Peers see low byte only
  assign reg_wdata_o  = sys_wdata_i;

  assign hit_hk   = (region == `RP_REGION_HK);
  assign hit_gen  = (region == `RP_REGION_GEN);
  assign hit_pc   = (region == `RP_REGION_PC);
  assign unmapped = ~(hit_hk | hit_gen | hit_pc);  // Regions 3 to 7
  assign strobe   = sys_wen_i | sys_ren_i;

  // Strobe goes to the addressed peer only
  assign hk_wen_o  = sys_wen_i & hit_hk;
  assign hk_ren_o  = sys_ren_i & hit_hk;
  assign gen_wen_o = sys_wen_i & hit_gen;
  assign gen_ren_o = sys_ren_i & hit_gen;
  assign pc_wen_o  = sys_wen_i & hit_pc;
  assign pc_ren_o  = sys_ren_i & hit_pc;

  //////////////////////////////
  // Pending access and response

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      pend_q <= '0;
      err_q  <= 1'b0;
    end else begin
      if (strobe)
        pend_q <= region;  // Held until the next strobe
      err_q <= strobe & unmapped;  // Ack with err one cycle later
    end
  end

  assign sys_err_o = err_q;

  // Response mux follows the pending region
  always_comb begin
    sys_rdata_o = '0;  // Unmapped reads as zero
    sys_ack_o   = err_q;
    case (pend_q)
      `RP_REGION_HK: begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
      end
      `RP_REGION_GEN: begin
        sys_rdata_o = gen_rdata_i;
        sys_ack_o   = gen_ack_i;
      end
      `RP_REGION_PC: begin
        sys_rdata_o = pc_rdata_i;
        sys_ack_o   = pc_ack_i;
      end
      default: ;
    endcase
  end

endmodule

//--- design/housekeeping.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module housekeeping (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  rp_pkg::reg_offset_t reg_offset_i,
  input  rp_pkg::bus_data_t   reg_wdata_i,
  input  logic                wen_i,
  input  logic                ren_i,
  output rp_pkg::bus_data_t   rdata_o,
  output logic                ack_o,
  output rp_pkg::led_t        led_o,
  output logic                digital_loop_o
);
  import rp_pkg::*;

  bus_data_t rd_mux;  // Read value ahead of the response register

  // Readback, unknown offsets give zero
  always_comb begin
    case (reg_offset_i)
      `RP_HK_ID_OFS:   rd_mux = `RP_ID_VALUE;
      `RP_HK_LED_OFS:  rd_mux = {{(`RP_BUS_DW-`RP_LED_W){1'b0}}, led_o};
      `RP_HK_LOOP_OFS: rd_mux = {{(`RP_BUS_DW-1){1'b0}}, digital_loop_o};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      led_o          <= '0;
      digital_loop_o <= 1'b0;
      rdata_o        <= '0;
      ack_o          <= 1'b0;
    end else begin
      ack_o <= wen_i | ren_i;  // Every strobe answered next cycle
      if (ren_i)
        rdata_o <= rd_mux;
      if (wen_i) begin
        case (reg_offset_i)
          `RP_HK_LED_OFS:  led_o <= reg_wdata_i[`RP_LED_W-1:0];
          `RP_HK_LOOP_OFS: digital_loop_o <= reg_wdata_i[0];  // DAC fed back to ADC
          default: ;  // ID stays fixed
        endcase
      end
    end
  end

endmodule

//--- design/dc_level_gen.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module dc_level_gen (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  rp_pkg::reg_offset_t reg_offset_i,
  input  rp_pkg::bus_data_t   reg_wdata_i,
  input  logic                wen_i,
  input  logic                ren_i,
  output rp_pkg::bus_data_t   rdata_o,
  output logic                ack_o,
  output rp_pkg::dac_sample_t lvl_a_o,
  output rp_pkg::dac_sample_t lvl_b_o
);
  import rp_pkg::*;

  bus_data_t rd_mux;

  // Levels read back sign extended
  always_comb begin
    case (reg_offset_i)
      `RP_GEN_LVL_A_OFS: rd_mux = {{(`RP_BUS_DW-`RP_DAC_W){lvl_a_o[`RP_DAC_W-1]}}, lvl_a_o};
      `RP_GEN_LVL_B_OFS: rd_mux = {{(`RP_BUS_DW-`RP_DAC_W){lvl_b_o[`RP_DAC_W-1]}}, lvl_b_o};
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      lvl_a_o <= '0;
      lvl_b_o <= '0;
      rdata_o <= '0;
      ack_o   <= 1'b0;
    end else begin
      ack_o <= wen_i | ren_i;
      if (ren_i)
        rdata_o <= rd_mux;
      if (wen_i) begin
        case (reg_offset_i)
          `RP_GEN_LVL_A_OFS: lvl_a_o <= reg_wdata_i[`RP_DAC_W-1:0];  // Low 14 bits only
          `RP_GEN_LVL_B_OFS: lvl_b_o <= reg_wdata_i[`RP_DAC_W-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

//--- design/p_controller.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module p_controller (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  rp_pkg::reg_offset_t reg_offset_i,
  input  rp_pkg::bus_data_t   reg_wdata_i,
  input  logic                wen_i,
  input  logic                ren_i,
  output rp_pkg::bus_data_t   rdata_o,
  output logic                ack_o,
  input  rp_pkg::adc_sample_t adc_a_i,
  input  rp_pkg::adc_sample_t adc_b_i,
  output rp_pkg::adc_sample_t pid_a_o,
  output rp_pkg::adc_sample_t pid_b_o
);
  import rp_pkg::*;

  adc_sample_t sp_a;  // Setpoints
  adc_sample_t sp_b;
  kp_t         kp_a;  // Gains
  kp_t         kp_b;
  bus_data_t   rd_mux;

  // (sp - sample) * kp >>> shift, clamped to 16 bits
  function automatic adc_sample_t p_term(input adc_sample_t sp, input adc_sample_t smp,
                                         input kp_t kp);
    logic signed [`RP_ADC_W:0]          err;   // One guard bit
    logic signed [`RP_ADC_W+`RP_KP_W:0] prod;  // Full product width
    logic signed [`RP_ADC_W+`RP_KP_W:0] shr;
    err  = $signed({sp[`RP_ADC_W-1], sp}) - $signed({smp[`RP_ADC_W-1], smp});
    prod = $signed({{`RP_KP_W{err[`RP_ADC_W]}}, err})
         * $signed({{(`RP_ADC_W+1){kp[`RP_KP_W-1]}}, kp});
    shr  = prod >>> `RP_KP_SHIFT;  // Arithmetic, keeps sign
    // Upper bits all equal means it fits
    if (shr[`RP_ADC_W+`RP_KP_W:`RP_ADC_W-1] == {(`RP_KP_W+2){shr[`RP_ADC_W+`RP_KP_W]}})
      p_term = shr[`RP_ADC_W-1:0];
    else if (shr[`RP_ADC_W+`RP_KP_W])
      p_term = {1'b1, {(`RP_ADC_W-1){1'b0}}};  // Negative full scale
    else
      p_term = {1'b0, {(`RP_ADC_W-1){1'b1}}};  // Positive full scale
  endfunction

  //////////////////////////////
  // Register access

  always_comb begin
    case (reg_offset_i)
      `RP_PC_SP_A_OFS: rd_mux = {{(`RP_BUS_DW-`RP_ADC_W){sp_a[`RP_ADC_W-1]}}, sp_a};
      `RP_PC_SP_B_OFS: rd_mux = {{(`RP_BUS_DW-`RP_ADC_W){sp_b[`RP_ADC_W-1]}}, sp_b};
      `RP_PC_KP_A_OFS: rd_mux = {{(`RP_BUS_DW-`RP_KP_W){kp_a[`RP_KP_W-1]}}, kp_a};
      `RP_PC_KP_B_OFS: rd_mux = {{(`RP_BUS_DW-`RP_KP_W){kp_b[`RP_KP_W-1]}}, kp_b};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      sp_a    <= '0;
      sp_b    <= '0;
      kp_a    <= '0;
      kp_b    <= '0;
      rdata_o <= '0;
      ack_o   <= 1'b0;
    end else begin
      ack_o <= wen_i | ren_i;
      if (ren_i)
        rdata_o <= rd_mux;
      if (wen_i) begin
        case (reg_offset_i)
          `RP_PC_SP_A_OFS: sp_a <= reg_wdata_i[`RP_ADC_W-1:0];
          `RP_PC_SP_B_OFS: sp_b <= reg_wdata_i[`RP_ADC_W-1:0];
          `RP_PC_KP_A_OFS: kp_a <= reg_wdata_i[`RP_KP_W-1:0];
          `RP_PC_KP_B_OFS: kp_b <= reg_wdata_i[`RP_KP_W-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // Feedback, one register stage

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      pid_a_o <= '0;
      pid_b_o <= '0;
    end else begin
      pid_a_o <= p_term(sp_a, adc_a_i, kp_a);
      pid_b_o <= p_term(sp_b, adc_b_i, kp_b);
    end
  end

endmodule

//--- design/adc_frontend.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module adc_frontend (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic [`RP_ADC_W-1:0] adc_a_i,  // Raw negative-slope codes
  input  logic [`RP_ADC_W-1:0] adc_b_i,
  input  logic                digital_loop_i,
  input  rp_pkg::dac_sample_t dac_sum_a_i,
  input  rp_pkg::dac_sample_t dac_sum_b_i,
  output rp_pkg::adc_sample_t adc_a_o,
  output rp_pkg::adc_sample_t adc_b_o
);
  import rp_pkg::*;

  adc_sample_t conv_a;  // Two's complement of the raw code
  adc_sample_t conv_b;
  adc_sample_t loop_a;  // DAC value, zero extended
  adc_sample_t loop_b;

  // Keep MSB, flip the rest
  assign conv_a = {adc_a_i[`RP_ADC_W-1], ~adc_a_i[`RP_ADC_W-2:0]};
  assign conv_b = {adc_b_i[`RP_ADC_W-1], ~adc_b_i[`RP_ADC_W-2:0]};
  assign loop_a = {{(`RP_ADC_W-`RP_DAC_W){1'b0}}, dac_sum_a_i};
  assign loop_b = {{(`RP_ADC_W-`RP_DAC_W){1'b0}}, dac_sum_b_i};

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= digital_loop_i ? loop_a : conv_a;  // External inputs ignored in loop
      adc_b_o <= digital_loop_i ? loop_b : conv_b;
    end
  end

endmodule

//--- design/dac_backend.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module dac_backend (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  input  rp_pkg::dac_sample_t  lvl_a_i,
  input  rp_pkg::dac_sample_t  lvl_b_i,
  input  rp_pkg::adc_sample_t  pid_a_i,
  input  rp_pkg::adc_sample_t  pid_b_i,
  output rp_pkg::dac_sample_t  dac_sum_a_o,  // Saturated sum, for the loop
  output rp_pkg::dac_sample_t  dac_sum_b_o,
  output logic [`RP_DAC_W-1:0] dac_a_o,      // Offset binary, negative slope
  output logic [`RP_DAC_W-1:0] dac_b_o
);
  import rp_pkg::*;

  dac_sample_t sat_a;
  dac_sample_t sat_b;

  // Level plus feedback in 17 bits, clamped to 14
  function automatic dac_sample_t sat_sum(input dac_sample_t lvl, input adc_sample_t pid);
    logic signed [`RP_ADC_W:0] sum;
    sum = $signed({{(`RP_ADC_W+1-`RP_DAC_W){lvl[`RP_DAC_W-1]}}, lvl})
        + $signed({pid[`RP_ADC_W-1], pid});
    if (sum[`RP_ADC_W:`RP_DAC_W-1] == {(`RP_ADC_W-`RP_DAC_W+2){sum[`RP_ADC_W]}})
      sat_sum = sum[`RP_DAC_W-1:0];
    else
      sat_sum = {sum[`RP_ADC_W], {(`RP_DAC_W-1){~sum[`RP_ADC_W]}}};  // Rail on sign
  endfunction

  assign sat_a = sat_sum(lvl_a_i, pid_a_i);
  assign sat_b = sat_sum(lvl_b_i, pid_b_i);

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_sum_a_o <= '0;
      dac_sum_b_o <= '0;
      dac_a_o     <= {1'b0, {(`RP_DAC_W-1){1'b1}}};  // Code for zero
      dac_b_o     <= {1'b0, {(`RP_DAC_W-1){1'b1}}};
    end else begin
      dac_sum_a_o <= sat_a;
      dac_sum_b_o <= sat_b;
      dac_a_o     <= {sat_a[`RP_DAC_W-1], ~sat_a[`RP_DAC_W-2:0]};
      dac_b_o     <= {sat_b[`RP_DAC_W-1], ~sat_b[`RP_DAC_W-2:0]};
    end
  end

endmodule

//--- design/rp_top.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_top (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  // ADC, raw codes
  input  logic [`RP_ADC_W-1:0] adc_a_i,
  input  logic [`RP_ADC_W-1:0] adc_b_i,
  // System bus
  input  rp_pkg::bus_addr_t    sys_addr_i,
  input  rp_pkg::bus_data_t    sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output rp_pkg::bus_data_t    sys_rdata_o,
  output logic                 sys_ack_o,
  output logic                 sys_err_o,
  // DAC, raw codes
  output logic [`RP_DAC_W-1:0] dac_a_o,
  output logic [`RP_DAC_W-1:0] dac_b_o,
  output rp_pkg::led_t         led_o
);
  import rp_pkg::*;

  // Peer bus
  reg_offset_t reg_offset;
  bus_data_t   reg_wdata;
  logic        hk_wen, hk_ren, hk_ack;
  logic        gen_wen, gen_ren, gen_ack;
  logic        pc_wen, pc_ren, pc_ack;
  bus_data_t   hk_rdata, gen_rdata, pc_rdata;

  // Sample path
  logic        digital_loop;
  adc_sample_t adc_dat_a, adc_dat_b;
  adc_sample_t pid_dat_a, pid_dat_b;
  dac_sample_t lvl_a, lvl_b;
  dac_sample_t dac_sum_a, dac_sum_b;

  //////////////////////////////
  // Bus

  sys_bus_decoder i_dec (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .sys_err_o    (sys_err_o),
    .reg_offset_o (reg_offset),
    .reg_wdata_o  (reg_wdata),
    .hk_wen_o     (hk_wen),
    .hk_ren_o     (hk_ren),
    .hk_rdata_i   (hk_rdata),
    .hk_ack_i     (hk_ack),
    .gen_wen_o    (gen_wen),
    .gen_ren_o    (gen_ren),
    .gen_rdata_i  (gen_rdata),
    .gen_ack_i    (gen_ack),
    .pc_wen_o     (pc_wen),
    .pc_ren_o     (pc_ren),
    .pc_rdata_i   (pc_rdata),
    .pc_ack_i     (pc_ack)
  );

  housekeeping i_hk (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .reg_offset_i   (reg_offset),
    .reg_wdata_i    (reg_wdata),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  //////////////////////////////
  // Analog path

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_a_i        (adc_a_i),
    .adc_b_i        (adc_b_i),
    .digital_loop_i (digital_loop),
    .dac_sum_a_i    (dac_sum_a),  // Loop back from the DAC stage
    .dac_sum_b_i    (dac_sum_b),
    .adc_a_o        (adc_dat_a),
    .adc_b_o        (adc_dat_b)
  );

  p_controller i_pc (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .wen_i        (pc_wen),
    .ren_i        (pc_ren),
    .rdata_o      (pc_rdata),
    .ack_o        (pc_ack),
    .adc_a_i      (adc_dat_a),
    .adc_b_i      (adc_dat_b),
    .pid_a_o      (pid_dat_a),
    .pid_b_o      (pid_dat_b)
  );

  dc_level_gen i_gen (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .wen_i        (gen_wen),
    .ren_i        (gen_ren),
    .rdata_o      (gen_rdata),
    .ack_o        (gen_ack),
    .lvl_a_o      (lvl_a),
    .lvl_b_o      (lvl_b)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .lvl_a_i     (lvl_a),
    .lvl_b_i     (lvl_b),
    .pid_a_i     (pid_dat_a),
    .pid_b_i     (pid_dat_b),
    .dac_sum_a_o (dac_sum_a),
    .dac_sum_b_o (dac_sum_b),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

endmodule

//--- tests/rp_top_chk.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_top_chk (
  input logic                 adc_clk,
  input logic                 reset_i,
  input logic                 sys_wen_i,
  input logic                 sys_ren_i,
  input logic                 sys_ack_o,
  input logic                 sys_err_o,
  input rp_pkg::led_t         led_o,
  input logic [`RP_DAC_W-1:0] dac_a_o,
  input logic [`RP_DAC_W-1:0] dac_b_o
);

  // Ack follows each strobe by exactly one cycle
  a_strobe_ack: assert property (@(posedge adc_clk) disable iff (reset_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o) else $error("strobe without ack");
  a_ack_origin: assert property (@(posedge adc_clk) disable iff (reset_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i)) else $error("ack without strobe");

  a_err_ack: assert property (@(posedge adc_clk) sys_err_o |-> sys_ack_o)
    else $error("err raised without ack");

  // Reset values visible in the first cycle out of reset
  a_reset_vals: assert property (@(posedge adc_clk) $fell(reset_i) |->
    (led_o == '0) && !sys_ack_o && (dac_a_o == 14'h1FFF) && (dac_b_o == 14'h1FFF))
    else $error("outputs not at reset values after reset");

endmodule

bind rp_top rp_top_chk i_chk (
  .adc_clk   (adc_clk),
  .reset_i   (reset_i),
  .sys_wen_i (sys_wen_i),
  .sys_ren_i (sys_ren_i),
  .sys_ack_o (sys_ack_o),
  .sys_err_o (sys_err_o),
  .led_o     (led_o),
  .dac_a_o   (dac_a_o),
  .dac_b_o   (dac_b_o)
);

//--- tests/rp_top_tb.sv
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_top_tb;
  import rp_pkg::*;

  localparam int RESET_CYC = 8;
  localparam int N_FB      = 24;   // Feedback samples
  localparam int LOOP_CYC  = 40;
  localparam int BUS_OPS   = 80;   // Upper bound on bus accesses, 3 cycles each
  localparam int WATCHDOG_CYC = RESET_CYC + BUS_OPS * 3 + N_FB * 5 + LOOP_CYC + 200;

  logic adc_clk, reset_i, sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  logic [15:0] adc_a_i, adc_b_i;
  logic [13:0] dac_a_o, dac_b_o;
  bus_addr_t sys_addr_i;
  bus_data_t sys_wdata_i, sys_rdata_o;
  led_t led_o;

  logic [31:0] rng;
  int errors, checks;
  string name_q[$];            // Pending comparisons
  logic [31:0] exp_q[$], act_q[$];

  rp_top UUT (.*);

  always #5 adc_clk = ~adc_clk;

  //////////////////////////////
  // Reference model

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic int clamp(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  function automatic int conv_raw(input logic [15:0] raw);
    return int'($signed(raw ^ 16'h7FFF));  // Negative slope to two's complement
  endfunction

  function automatic int p_ref(input int sp, input int smp, input int kp);
    return clamp(((sp - smp) * kp) >>> 4, -32768, 32767);
  endfunction

  function automatic int sum_ref(input int lvl, input int p);
    return clamp(lvl + p, -8192, 8191);
  endfunction

  function automatic logic [13:0] code_ref(input int s);
    logic [13:0] b;
    b = 14'(s);
    return {b[13], ~b[12:0]};  // Offset binary, negative slope
  endfunction

  function automatic logic [13:0] ref_dac(input logic [15:0] raw, input int sp,
                                         input int kp, input int lvl);
    return code_ref(sum_ref(lvl, p_ref(sp, conv_raw(raw), kp)));
  endfunction

  //////////////////////////////
  // Bus and compare helpers

  function automatic logic [31:0] addr(input int region, input logic [7:0] ofs);
    return (32'(region) << 20) | {24'h0, ofs};
  endfunction

  task automatic expect_val(input string name, input logic [31:0] e, input logic [31:0] a);
    name_q.push_back(name);
    exp_q.push_back(e);
    act_q.push_back(a);
  endtask

  task automatic wait_ack(output logic [31:0] data, output logic err);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && n < 8) begin
      n++;
      @(negedge adc_clk);
    end
    if (!sys_ack_o) begin
      $display("bus access at %h got no ack", sys_addr_i);
      errors++;
    end
    data = sys_rdata_o;
    err  = sys_err_o;
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [31:0] d, output logic err);
    logic [31:0] unused_rd;
    @(posedge adc_clk);
    sys_addr_i  <= a;
    sys_wdata_i <= d;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;  // Register takes the value at this edge
    wait_ack(unused_rd, err);
  endtask

  task automatic bus_read(input logic [31:0] a, output logic [31:0] d, output logic err);
    @(posedge adc_clk);
    sys_addr_i <= a;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack(d, err);
  endtask

  task automatic wr_chk(input int region, input logic [7:0] ofs, input logic [31:0] d);
    logic err;
    bus_write(addr(region, ofs), d, err);
    expect_val("mapped write err", 32'h0, 32'(err));
  endtask

  task automatic rd_chk(input string name, input int region, input logic [7:0] ofs,
                        input logic [31:0] e);
    logic [31:0] d;
    logic err;
    bus_read(addr(region, ofs), d, err);
    expect_val(name, e, d);
    expect_val("mapped read err", 32'h0, 32'(err));
  endtask

  // Comparing process, drains whatever the stimulus queued
  always @(negedge adc_clk) begin
    while (exp_q.size() > 0) begin
      checks++;
      if (exp_q[0] != act_q[0]) begin
        $display("mismatch %s expected %0h actual %0h", name_q[0], exp_q[0], act_q[0]);
        errors++;
      end
      void'(name_q.pop_front());
      void'(exp_q.pop_front());
      void'(act_q.pop_front());
    end
  end

  initial begin
    #(WATCHDOG_CYC * 10);
    $display("Watchdog expired, simulation did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////
  // Stimulus

  initial begin
    logic [31:0] r, d;
    logic err;
    int sp_a, sp_b, kp_a, kp_b, lvl_a, lvl_b, la, lp, ls, na, np;
    adc_clk = 1'b0;
    reset_i = 1'b1;
    sys_addr_i = '0;
    sys_wdata_i = '0;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    adc_a_i = '0;
    adc_b_i = '0;
    rng = 32'h8bd56c13;
    errors = 0;
    checks = 0;
    repeat (RESET_CYC) @(posedge adc_clk);
    reset_i <= 1'b0;

    // Registers and readback
    rd_chk("id", 0, `RP_HK_ID_OFS, `RP_ID_VALUE);
    wr_chk(0, `RP_HK_ID_OFS, next_rand());
    rd_chk("id after write", 0, `RP_HK_ID_OFS, `RP_ID_VALUE);
    repeat (3) begin
      d = next_rand();
      wr_chk(0, `RP_HK_LED_OFS, d);
      expect_val("led_o", {24'h0, d[7:0]}, {24'h0, led_o});
      rd_chk("led read", 0, `RP_HK_LED_OFS, {24'h0, d[7:0]});
    end
    for (int i = 0; i < 2; i++) begin
      d = next_rand();
      wr_chk(1, 8'(i * 4), d);
      rd_chk("level read", 1, 8'(i * 4), {{18{d[13]}}, d[13:0]});
      d = next_rand();
      wr_chk(2, 8'(i * 4), d);
      rd_chk("setpoint read", 2, 8'(i * 4), {{16{d[15]}}, d[15:0]});
      d = next_rand();
      wr_chk(2, 8'(8 + i * 4), d);
      rd_chk("gain read", 2, 8'(8 + i * 4), {{24{d[7]}}, d[7:0]});
    end

    // Unmapped regions answer with err and zero data
    for (int reg_n = 3; reg_n < 8; reg_n++) begin
      bus_read(addr(reg_n, 8'h04), r, err);
      expect_val("unmapped rdata", 32'h0, r);
      expect_val("unmapped read err", 32'h1, 32'(err));
      bus_write(addr(reg_n, 8'h00), next_rand(), err);
      expect_val("unmapped write err", 32'h1, 32'(err));
    end

    // DC level with zero gain
    wr_chk(2, `RP_PC_KP_A_OFS, 32'h0);
    wr_chk(2, `RP_PC_KP_B_OFS, 32'h0);
    repeat (2) begin
      r = next_rand();
      lvl_a = int'($signed(r[13:0]));
      wr_chk(1, `RP_GEN_LVL_A_OFS, r);
      @(negedge adc_clk);
      expect_val("dc level a", 32'(code_ref(lvl_a)), 32'(dac_a_o));
      r = next_rand();
      lvl_b = int'($signed(r[13:0]));
      wr_chk(1, `RP_GEN_LVL_B_OFS, r);
      @(negedge adc_clk);
      expect_val("dc level b", 32'(code_ref(lvl_b)), 32'(dac_b_o));
    end

    // Feedback path with random setpoint and gain
    r = next_rand();
    sp_a = int'($signed(r[15:0]));
    sp_b = int'($signed(r[31:16]));
    wr_chk(2, `RP_PC_SP_A_OFS, r);
    wr_chk(2, `RP_PC_SP_B_OFS, {16'h0, r[31:16]});
    r = next_rand();
    kp_a = int'($signed(r[7:0]));
    kp_b = int'($signed(r[15:8]));
    wr_chk(2, `RP_PC_KP_A_OFS, r);
    wr_chk(2, `RP_PC_KP_B_OFS, {24'h0, r[15:8]});
    for (int i = 0; i < N_FB; i++) begin
      r = next_rand();
      @(posedge adc_clk);
      adc_a_i <= r[15:0];
      adc_b_i <= r[31:16];
      repeat (3) @(posedge adc_clk);  // Frontend, controller, DAC stage
      @(negedge adc_clk);
      expect_val("feedback a", 32'(ref_dac(r[15:0], sp_a, kp_a, lvl_a)), 32'(dac_a_o));
      expect_val("feedback b", 32'(ref_dac(r[31:16], sp_b, kp_b, lvl_b)), 32'(dac_b_o));
    end

    // Sum saturation, both rails
    wr_chk(1, `RP_GEN_LVL_A_OFS, 32'(8000));
    wr_chk(1, `RP_GEN_LVL_B_OFS, 32'(-8000));
    wr_chk(2, `RP_PC_SP_A_OFS, 32'h7FFF);
    wr_chk(2, `RP_PC_SP_B_OFS, 32'h8000);
    wr_chk(2, `RP_PC_KP_A_OFS, 32'd127);
    wr_chk(2, `RP_PC_KP_B_OFS, 32'd127);
    @(posedge adc_clk);
    adc_a_i <= 16'hFFFF;  // Most negative sample
    adc_b_i <= 16'h0000;  // Most positive sample
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    expect_val("saturate high", 32'(ref_dac(16'hFFFF, 32767, 127, 8000)), 32'(dac_a_o));
    expect_val("rail high", 32'h0000, 32'(dac_a_o));
    expect_val("saturate low", 32'(ref_dac(16'h0000, -32768, 127, -8000)), 32'(dac_b_o));
    expect_val("rail low", 32'h3FFF, 32'(dac_b_o));

    // Digital loop, settle with zero gain first
    wr_chk(2, `RP_PC_KP_A_OFS, 32'h0);
    wr_chk(2, `RP_PC_KP_B_OFS, 32'h0);
    r = next_rand();
    sp_a = int'($signed(r[11:0]));
    lvl_a = int'($signed(r[27:16]));
    wr_chk(2, `RP_PC_SP_A_OFS, {{20{r[11]}}, r[11:0]});
    wr_chk(1, `RP_GEN_LVL_A_OFS, {{20{r[27]}}, r[27:16]});
    r = next_rand();
    @(posedge adc_clk);
    adc_a_i <= r[15:0];  // Must be ignored once the loop is closed
    adc_b_i <= r[31:16];
    wr_chk(0, `RP_HK_LOOP_OFS, 32'h1);
    wr_chk(2, `RP_PC_KP_A_OFS, 32'd8);
    la = lvl_a & 32'h3FFF;  // Pipeline state at the gain update edge
    lp = 0;
    ls = lvl_a;
    repeat (LOOP_CYC) begin
      @(negedge adc_clk);
      na = ls & 32'h3FFF;
      np = p_ref(sp_a, la, 8);
      ls = sum_ref(lvl_a, lp);
      la = na;
      lp = np;
    end
    expect_val("digital loop", 32'(code_ref(ls)), 32'(dac_a_o));

    repeat (2) @(negedge adc_clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+design
design/rp_pkg.sv
design/sys_bus_decoder.sv
design/housekeeping.sv
design/dc_level_gen.sv
design/p_controller.sv
design/adc_frontend.sv
design/dac_backend.sv
design/rp_top.sv
tests/rp_top_chk.sv
tests/rp_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rp_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module rp_top_tb -o rp_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/rp_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
